//--- spio_pkt_pkg.sv
// packet widths, flit counts and packet port struct types
package spio_pkt_pkg;

  // --------------------------------------------------
  // packet format
  // --------------------------------------------------
  localparam int pkt_bits   = 72;  // long packet, full word
  localparam int short_bits = 40;  // short packet, low part of word
  localparam int long_bit   = 1;   // set means long packet

  typedef logic [pkt_bits-1:0] pkt_data_t;  // packet payload
  typedef logic [4:0]          nib_cnt_t;   // nibble (flit) counter

  // nibbles per packet, eop not counted
  localparam nib_cnt_t short_flits = nib_cnt_t'(short_bits / 4);
  localparam nib_cnt_t long_flits  = nib_cnt_t'(pkt_bits / 4);

  // --------------------------------------------------
  // packet port bundle, rdy travels the other way
  // --------------------------------------------------
  typedef struct packed {
    pkt_data_t data;  // short packets use the low 40 bits
    logic      vld;
  } pkt_req_t;

endpackage

//--- spio_code_pkg.sv
// 2-of-7 link code table, symbol and flit types, nrz encode and decode functions
package spio_code_pkg;

  typedef logic [6:0] sym_t;  // one word on the 7 link wires
  typedef logic [4:0] nib_t;  // code index, msb set for eop

  // flit port bundle, rdy travels the other way
  typedef struct packed {
    nib_t code;
    logic vld;
  } flit_t;

  localparam int n_codes = 17;  // 16 nibbles plus eop

  // --------------------------------------------------
  // wire pairs toggled for each code, eop last
  // --------------------------------------------------
  localparam sym_t code_table [0:n_codes-1] = '{
    7'b0010001, 7'b0010010, 7'b0010100, 7'b0011000,  // 0..3
    7'b0100001, 7'b0100010, 7'b0100100, 7'b0101000,  // 4..7
    7'b1000001, 7'b1000010, 7'b1000100, 7'b1001000,  // 8..11
    7'b0000011, 7'b0000110, 7'b0001100, 7'b0001001,  // 12..15
    7'b1100000                                       // eop
  };

  // nrz: new word is old word with the code's two wires flipped
  function automatic sym_t encode_nrz(sym_t old_word, nib_t nib);
    sym_t delta;
    if (nib[4]) begin
      delta = code_table[n_codes-1];  // any eop index
    end else begin
      delta = code_table[nib[3:0]];
    end
    return old_word ^ delta;
  endfunction

  // transition pattern back to code index, vld clear if no match
  function automatic flit_t decode_sym(sym_t trans);
    flit_t res;
    res = '0;
    for (int i = 0; i < n_codes; i++) begin
      if (trans == code_table[i]) begin
        res.code = nib_t'(i);  // 16 lands on eop
        res.vld  = 1'b1;
      end
    end
    return res;
  endfunction

endpackage

//--- spio_sync.sv
// two-flop synchronizer for asynchronous link wires
`timescale 1ns/1ps

module spio_sync #(
  parameter int WIDTH = 1  // 1 for ack, 7 for data
) (
  input  logic             CLK_IN,
  input  logic             RESET_IN,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] meta;  // first stage, may go metastable

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      meta <= '0;
      dout <= '0;
    end else begin
      meta <= din;
      dout <= meta;  // 2 cycles from pin to core
    end
  end

endmodule

//--- spio_pkt_serializer.sv
// packet to nibble serializer with park state and end-of-packet generation
`timescale 1ns/1ps

module spio_pkt_serializer (
  input  logic                   CLK_IN,
  input  logic                   RESET_IN,
  input  spio_pkt_pkg::pkt_req_t pkt,
  output logic                   pkt_rdy,
  output spio_code_pkg::flit_t   flit,
  input  logic                   flit_rdy
);

  typedef enum logic [1:0] {
    st_idle,  // waiting for a packet
    st_park,  // packet held, flit port still busy with last eop
    st_tran   // sending nibbles
  } ser_state_t;

  ser_state_t              state;
  spio_pkt_pkg::pkt_data_t pkt_buf;    // packet, shifted as nibbles go
  logic                    long_pkt;   // latched length flag
  spio_pkt_pkg::nib_cnt_t  flit_cnt;   // nibbles handed over so far
  spio_code_pkg::nib_t     flit_code;
  logic                    flit_vld;
  logic                    flit_busy;  // flit offered but not taken
  logic                    eop;        // all nibbles gone, eop next

  always_comb flit_busy = flit_vld && !flit_rdy;

  always_comb begin
    eop = (!long_pkt && (flit_cnt == spio_pkt_pkg::short_flits))
          || (flit_cnt == spio_pkt_pkg::long_flits);
  end

  assign flit = '{code: flit_code, vld: flit_vld};

  // --------------------------------------------------
  // packet port
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_rdy <= 1'b1;
    end else begin
      case (state)
        st_idle: pkt_rdy <= !pkt.vld;              // drop on accept
        st_park: pkt_rdy <= 1'b0;
        default: pkt_rdy <= eop && !flit_busy;     // up once eop handed over
      endcase
    end
  end

  // payload buffer, no reset
  always_ff @(posedge CLK_IN) begin
    case (state)
      st_idle: begin
        if (pkt.vld) begin
          if (flit_busy) begin
            pkt_buf <= pkt.data;       // park whole packet
          end else begin
            pkt_buf <= pkt.data >> 4;  // nibble 0 goes out now
          end
        end
      end
      default: if (!flit_busy) pkt_buf <= pkt_buf >> 4;
    endcase
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      long_pkt <= 1'b0;
    end else if ((state == st_idle) && pkt.vld) begin
      long_pkt <= pkt.data[spio_pkt_pkg::long_bit];
    end
  end

  // --------------------------------------------------
  // flit port
  // --------------------------------------------------
  always_ff @(posedge CLK_IN) begin
    case (state)
      st_idle: if (pkt.vld && !flit_busy) flit_code <= {1'b0, pkt.data[3:0]};
      default: if (!flit_busy) flit_code <= {eop, pkt_buf[3:0]};  // nibble or eop
    endcase
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_vld <= 1'b0;
    end else begin
      case (state)
        st_idle: if (!flit_busy) flit_vld <= pkt.vld;
        default: flit_vld <= 1'b1;  // always another flit or eop
      endcase
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_cnt <= '0;
    end else begin
      case (state)
        st_idle,
        st_park: flit_cnt <= spio_pkt_pkg::nib_cnt_t'(1);  // first nibble counted
        default: if (!flit_busy) flit_cnt <= flit_cnt + 1'b1;
      endcase
    end
  end

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (pkt.vld) state <= flit_busy ? st_park : st_tran;
        end
        st_park: if (!flit_busy) state <= st_tran;  // parked nibble 0 sent
        default: if (eop && !flit_busy) state <= st_idle;
      endcase
    end
  end

  // no second packet taken while one is in flight
  a_rdy_low_busy: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (state != st_idle) |-> !pkt_rdy);

endmodule

//--- spio_flit_output_if.sv
// flit output interface driving nrz 2-of-7 link words and tracking ack toggles
`timescale 1ns/1ps

module spio_flit_output_if (
  input  logic                 CLK_IN,
  input  logic                 RESET_IN,
  input  spio_code_pkg::flit_t flit,
  output logic                 flit_rdy,
  output spio_code_pkg::sym_t  sl_data,
  input  logic                 ack       // already synchronized
);

  typedef enum logic [1:0] {
    st_idle,  // link acked, nothing outstanding
    st_tran,  // symbol on the wires, waiting for ack
    st_wait   // next flit sent ahead of rdy, handshake this cycle
  } oif_state_t;

  oif_state_t state;
  logic       old_ack;    // ack level when last symbol went out
  logic       acked;
  logic       send_flit;

  always_comb acked = (old_ack != ack);  // any toggle is an ack

  // --------------------------------------------------
  // flit port
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_rdy <= 1'b1;
    end else begin
      case (state)
        st_idle: if (flit.vld) flit_rdy <= 1'b0;  // taken, hold off next
        default: flit_rdy <= acked;
      endcase
    end
  end

  always_comb begin
    case (state)
      st_idle: send_flit = flit.vld;
      st_tran: send_flit = acked && flit.vld;  // ack in, next one out
      default: send_flit = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // link side
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      sl_data <= '0;
    end else if (send_flit) begin
      sl_data <= spio_code_pkg::encode_nrz(sl_data, flit.code);
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      old_ack <= 1'b0;
    end else if (send_flit) begin
      old_ack <= ack;
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (flit.vld) state <= st_tran;
        st_tran: begin
          if (acked) state <= flit.vld ? st_wait : st_idle;
        end
        default: state <= acked ? st_idle : st_tran;
      endcase
    end
  end

  // remote decoder relies on exactly one wire pair per symbol
  a_two_wire_step: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    !$stable(sl_data) |-> ($countones(sl_data ^ $past(sl_data)) == 2));

endmodule

//--- spio_flit_input_if.sv
// flit input interface detecting 2-of-7 transitions, decoding and toggling ack
`timescale 1ns/1ps

module spio_flit_input_if (
  input  logic                 CLK_IN,
  input  logic                 RESET_IN,
  input  spio_code_pkg::sym_t  sl_data,   // already synchronized
  output spio_code_pkg::flit_t flit,
  input  logic                 flit_rdy,
  output logic                 ack
);

  spio_code_pkg::sym_t  old_word;   // last word we acked
  spio_code_pkg::sym_t  diff;       // wires changed since then
  spio_code_pkg::flit_t dec;
  spio_code_pkg::nib_t  flit_code;
  logic                 flit_vld;
  logic                 two_diff;   // complete symbol seen
  logic                 accept;     // retire symbol, toggle ack

  always_comb diff     = sl_data ^ old_word;
  always_comb two_diff = ($countones(diff) == 2);
  always_comb dec      = spio_code_pkg::decode_sym(diff);

  // taken downstream, or a bad pair dropped on the floor
  always_comb begin
    accept = (flit_vld && flit_rdy) || (!flit_vld && two_diff && !dec.vld);
  end

  assign flit = '{code: flit_code, vld: flit_vld};

  // --------------------------------------------------
  // decoded flit, held until rdy
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_vld <= 1'b0;
    end else if (!flit_vld) begin
      flit_vld <= two_diff && dec.vld;
    end else if (flit_rdy) begin
      flit_vld <= 1'b0;
    end
  end

  always_ff @(posedge CLK_IN) begin
    if (!flit_vld && two_diff) flit_code <= dec.code;  // payload, no reset
  end

  // --------------------------------------------------
  // ack back to remote sender
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      old_word <= '0;
      ack      <= 1'b0;
    end else if (accept) begin
      old_word <= sl_data;  // stable, remote still waits for ack
      ack      <= !ack;
    end
  end

  // remote sender never moves more than one pair ahead
  a_max_two_diff: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    !flit_vld |-> ($countones(diff) <= 2));

endmodule

//--- spio_pkt_deserializer.sv
// nibble to packet deserializer with held output and back-pressure on eop
`timescale 1ns/1ps

module spio_pkt_deserializer (
  input  logic                   CLK_IN,
  input  logic                   RESET_IN,
  input  spio_code_pkg::flit_t   flit,
  output logic                   flit_rdy,
  output spio_pkt_pkg::pkt_req_t pkt,
  input  logic                   pkt_rdy
);

  spio_pkt_pkg::pkt_data_t sh_buf;    // nibbles enter at the top
  spio_pkt_pkg::nib_cnt_t  nib_cnt;
  spio_pkt_pkg::pkt_data_t pkt_data;  // packet on offer
  logic                    pkt_vld;
  logic                    is_eop;
  logic                    take;      // flit handshake

  always_comb is_eop   = flit.code[4];
  always_comb flit_rdy = !(is_eop && pkt_vld);  // eop waits for free output
  always_comb take     = flit.vld && flit_rdy;

  assign pkt = '{data: pkt_data, vld: pkt_vld};

  // --------------------------------------------------
  // nibble assembly
  // --------------------------------------------------
  always_ff @(posedge CLK_IN) begin
    if (take && !is_eop) begin
      sh_buf <= {flit.code[3:0], sh_buf[spio_pkt_pkg::pkt_bits-1:4]};
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      nib_cnt <= '0;
    end else if (take) begin
      nib_cnt <= is_eop ? '0 : nib_cnt + 1'b1;  // restart per packet
    end
  end

  // --------------------------------------------------
  // packet output
  // --------------------------------------------------
  always_ff @(posedge CLK_IN) begin
    if (take && is_eop) begin
      if (nib_cnt == spio_pkt_pkg::short_flits) begin
        // short one sits in the top 40 bits, move it down
        pkt_data <= spio_pkt_pkg::pkt_data_t'(
          sh_buf[spio_pkt_pkg::pkt_bits-1 -: spio_pkt_pkg::short_bits]);
      end else begin
        pkt_data <= sh_buf;
      end
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_vld <= 1'b0;
    end else if (take && is_eop) begin
      pkt_vld <= 1'b1;
    end else if (pkt_rdy) begin
      pkt_vld <= 1'b0;
    end
  end

endmodule

//--- spio_link_endpoint.sv
// link endpoint top joining transmit path, receive path and synchronizers
`timescale 1ns/1ps

module spio_link_endpoint (
  input  logic                   CLK_IN,
  input  logic                   RESET_IN,
  // transmit packet port
  input  spio_pkt_pkg::pkt_req_t tx_pkt,
  output logic                   tx_rdy,
  // outgoing link
  output spio_code_pkg::sym_t    sl_tx_data,
  input  logic                   sl_tx_ack,
  // incoming link
  input  spio_code_pkg::sym_t    sl_rx_data,
  output logic                   sl_rx_ack,
  // receive packet port
  output spio_pkt_pkg::pkt_req_t rx_pkt,
  input  logic                   rx_rdy
);

  logic                 tx_ack_s;     // synced remote ack
  spio_code_pkg::sym_t  rx_data_s;    // synced remote data
  spio_code_pkg::flit_t tx_flit;
  logic                 tx_flit_rdy;
  spio_code_pkg::flit_t rx_flit;
  logic                 rx_flit_rdy;

  // --------------------------------------------------
  // transmit path
  // --------------------------------------------------
  spio_sync #(.WIDTH(1)) sync_ack_i (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .din      (sl_tx_ack),
    .dout     (tx_ack_s)
  );

  spio_pkt_serializer ser_i (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .pkt      (tx_pkt),
    .pkt_rdy  (tx_rdy),
    .flit     (tx_flit),
    .flit_rdy (tx_flit_rdy)
  );

  spio_flit_output_if fo_i (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .flit     (tx_flit),
    .flit_rdy (tx_flit_rdy),
    .sl_data  (sl_tx_data),
    .ack      (tx_ack_s)
  );

  // --------------------------------------------------
  // receive path
  // --------------------------------------------------
  spio_sync #(.WIDTH($bits(spio_code_pkg::sym_t))) sync_data_i (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .din      (sl_rx_data),
    .dout     (rx_data_s)
  );

  spio_flit_input_if fi_i (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .sl_data  (rx_data_s),
    .flit     (rx_flit),
    .flit_rdy (rx_flit_rdy),
    .ack      (sl_rx_ack)
  );

  spio_pkt_deserializer des_i (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .flit     (rx_flit),
    .flit_rdy (rx_flit_rdy),
    .pkt      (rx_pkt),
    .pkt_rdy  (rx_rdy)
  );

endmodule

//--- tb_spio_link.sv
// loopback testbench for the link endpoint: stimulus, reference model, checkers, watchdog
`timescale 1ns/1ps

module tb_spio_link;

  // --------------------------------------------------
  // run length and packet format constants
  // --------------------------------------------------
  localparam int clk_half   = 20;    // 40 ns period
  localparam int rst_cycles = 16;
  localparam int n_short    = 20;    // short packets, rx always ready
  localparam int n_mixed    = 24;    // mixed, back to back
  localparam int n_bp       = 30;    // mixed, rx back-pressured
  localparam int n_pkts     = n_short + n_mixed + n_bp;
  localparam int sym_max    = 19;    // 18 nibbles plus eop
  localparam int sym_cycles = 12;    // one link round trip
  localparam int wd_cycles  = n_pkts * sym_max * sym_cycles + n_pkts * 80 + 2000;
  localparam int short_w    = 40;    // bits carried by a short packet
  localparam int long_flag  = 1;     // length flag position
  localparam logic [6:0] eop_pair = 7'b1100000;  // wires flipped by eop

  logic                   CLK_IN;
  logic                   RESET_IN;
  spio_pkt_pkg::pkt_req_t tx_pkt;
  logic                   tx_rdy;
  spio_code_pkg::sym_t    sl_tx_data;
  logic                   sl_tx_ack;
  spio_code_pkg::sym_t    sl_rx_data;
  logic                   sl_rx_ack;
  spio_pkt_pkg::pkt_req_t rx_pkt;
  logic                   rx_rdy;

  integer                  seed = 32'h32e3;
  int                      err_val = 0;    // wrong values
  int                      err_other = 0;  // lost, extra or dropped
  int                      n_checks = 0;
  int                      n_rx = 0;       // packets taken from rx port
  int                      rdy_mode = 0;   // 0 ready, 1 random, 2 long stalls
  spio_pkt_pkg::pkt_data_t exp_q[$];       // expected packets in order
  int                      sym_q[$];       // expected symbols per packet
  logic                    hold_prev;      // rx offered, not taken last edge
  spio_pkt_pkg::pkt_data_t held_data;
  spio_code_pkg::sym_t     last_sym;
  int                      sym_cnt;

  spio_link_endpoint spio_link_endpoint_i (
    .CLK_IN     (CLK_IN),
    .RESET_IN   (RESET_IN),
    .tx_pkt     (tx_pkt),
    .tx_rdy     (tx_rdy),
    .sl_tx_data (sl_tx_data),
    .sl_tx_ack  (sl_tx_ack),
    .sl_rx_data (sl_rx_data),
    .sl_rx_ack  (sl_rx_ack),
    .rx_pkt     (rx_pkt),
    .rx_rdy     (rx_rdy)
  );

  // --------------------------------------------------
  // reference model and reporting
  // --------------------------------------------------
  function automatic spio_pkt_pkg::pkt_data_t expected_pkt(input spio_pkt_pkg::pkt_data_t sent);
    spio_pkt_pkg::pkt_data_t res;
    res = sent;
    if (!sent[long_flag]) res[71:short_w] = '0;  // upper part never sent
    return res;
  endfunction

  function automatic int expected_symbols(input spio_pkt_pkg::pkt_data_t sent);
    return sent[long_flag] ? 19 : 11;  // nibbles plus eop
  endfunction

  function automatic logic coin_flip();
    return ($random(seed) & 1) != 0;
  endfunction

  function automatic spio_pkt_pkg::pkt_data_t random_pkt(input logic is_long);
    spio_pkt_pkg::pkt_data_t d;
    d[31:0]  = $random(seed);
    d[63:32] = $random(seed);
    d[71:64] = 8'($random(seed));
    d[long_flag] = is_long;
    return d;
  endfunction

  task automatic check_value(input string name, input logic [71:0] got,
                             input logic [71:0] exp);
    n_checks++;
    if (got !== exp) begin
      err_val++;
      $display("FAILED time=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic other_error(input string what);
    err_other++;
    $display("ERROR time=%0t %s", $time, what);
  endtask

  task automatic print_counts();
    $display("summary: %0d checks, %0d value errors, %0d other errors",
             n_checks, err_val, err_other);
  endtask

  // one packet on tx port, vld kept high if hold
  task automatic send_pkt(input spio_pkt_pkg::pkt_data_t data, input logic hold);
    @(negedge CLK_IN);
    tx_pkt.data = data;
    tx_pkt.vld  = 1'b1;
    while (!tx_rdy) @(negedge CLK_IN);  // rdy is a flop, stable here
    exp_q.push_back(expected_pkt(data));
    sym_q.push_back(expected_symbols(data));
    @(posedge CLK_IN);  // transfer edge
    if (!hold) begin
      @(negedge CLK_IN);
      tx_pkt.vld = 1'b0;
    end
  endtask

  // --------------------------------------------------
  // clock, loopback delay lines, rx ready
  // --------------------------------------------------
  initial begin
    CLK_IN = 1'b0;
    forever #(clk_half) CLK_IN = ~CLK_IN;
  end

  initial begin : data_line
    int dly;
    sl_rx_data = '0;
    forever begin
      @(negedge CLK_IN);
      if (sl_tx_data !== sl_rx_data) begin
        dly = $random(seed) & 3;  // 0 to 3 cycles of wire delay
        repeat (dly) @(negedge CLK_IN);
        sl_rx_data = sl_tx_data;
      end
    end
  end

  initial begin : ack_line
    int dly;
    sl_tx_ack = 1'b0;
    forever begin
      @(negedge CLK_IN);
      if (sl_rx_ack !== sl_tx_ack) begin
        dly = $random(seed) & 3;
        repeat (dly) @(negedge CLK_IN);
        sl_tx_ack = sl_rx_ack;
      end
    end
  end

  initial begin : rdy_driver
    rx_rdy = 1'b1;
    forever begin
      @(negedge CLK_IN);
      case (rdy_mode)
        1: rx_rdy = coin_flip();
        2: begin
          if (($random(seed) & 3) == 0) begin
            rx_rdy = 1'b0;  // long stall
            repeat (16 + ($random(seed) & 31)) @(negedge CLK_IN);
          end
          rx_rdy = 1'b1;
        end
        default: rx_rdy = 1'b1;
      endcase
    end
  end

  // --------------------------------------------------
  // monitors, sampled on the rising edge
  // --------------------------------------------------
  always @(posedge CLK_IN) begin : rx_compare
    if (RESET_IN) begin
      hold_prev = 1'b0;
    end else begin
      if (hold_prev) begin
        if (!rx_pkt.vld) other_error("rx_pkt.vld dropped before the packet was taken");
        else check_value("rx_pkt.data held", rx_pkt.data, held_data);
      end
      if (rx_pkt.vld && rx_rdy) begin
        n_rx++;
        if (exp_q.size() == 0) other_error("packet received with none outstanding");
        else check_value("rx_pkt.data", rx_pkt.data, exp_q.pop_front());
      end
      hold_prev = rx_pkt.vld && !rx_rdy;
      held_data = rx_pkt.data;
    end
  end

  always @(posedge CLK_IN) begin : sym_monitor
    if (RESET_IN) begin
      last_sym = '0;
      sym_cnt  = 0;
    end else if (sl_tx_data !== last_sym) begin
      check_value("sl_tx_data wires changed", 72'($countones(sl_tx_data ^ last_sym)), 72'd2);
      sym_cnt++;
      if ((sl_tx_data ^ last_sym) == eop_pair) begin  // packet closed
        if (sym_q.size() == 0) other_error("eop sent with no packet outstanding");
        else check_value("symbols per packet", 72'(sym_cnt), 72'(sym_q.pop_front()));
        sym_cnt = 0;
      end
      last_sym = sl_tx_data;
    end
  end

  initial begin : watchdog
    repeat (wd_cycles) @(posedge CLK_IN);
    $display("timeout: packets not all received, %0d of %0d", n_rx, n_pkts);
    print_counts();
    $display("CHECKS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin : main
    int   i;
    logic hold;
    RESET_IN = 1'b1;
    tx_pkt   = '0;
    repeat (rst_cycles) @(negedge CLK_IN);
    RESET_IN = 1'b0;
    @(negedge CLK_IN);
    check_value("tx_rdy", 72'(tx_rdy), 72'd1);  // reset values
    check_value("rx_pkt.vld", 72'(rx_pkt.vld), 72'd0);
    check_value("sl_tx_data", 72'(sl_tx_data), 72'd0);
    check_value("sl_rx_ack", 72'(sl_rx_ack), 72'd0);

    for (i = 0; i < n_short; i++) begin  // short ones with idle gaps
      send_pkt(random_pkt(1'b0), 1'b0);
      repeat ($random(seed) & 3) @(negedge CLK_IN);
    end
    for (i = 0; i < n_mixed; i++) begin  // vld held, exercises park
      send_pkt(random_pkt(coin_flip()), i != n_mixed - 1);
    end
    for (i = 0; i < n_bp; i++) begin
      rdy_mode = (i < n_bp / 2) ? 1 : 2;
      hold = coin_flip() && (i != n_bp - 1);  // last one always released
      send_pkt(random_pkt(coin_flip()), hold);
    end

    while (exp_q.size() != 0) @(negedge CLK_IN);
    rdy_mode = 0;
    repeat (40) @(negedge CLK_IN);  // room for any extra packet
    check_value("packets received", 72'(n_rx), 72'(n_pkts));
    check_value("eop symbols missing", 72'(sym_q.size()), 72'd0);

    print_counts();
    if ((err_val + err_other) == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
spio_pkt_pkg.sv
spio_code_pkg.sv
spio_sync.sv
spio_pkt_serializer.sv
spio_flit_output_if.sv
spio_flit_input_if.sv
spio_pkt_deserializer.sv
spio_link_endpoint.sv
tb_spio_link.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps -Wall
TOP        = tb_spio_link
FILELIST   = tb.f
OBJ_DIR    = obj_dir
PASS_MSG   = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
